// File: common/adc_pkg.sv
// Widths and structs shared by the whole readout; FIFO_DEPTH must be a power of two
`default_nettype none

package adc_pkg;

    localparam int NUM_CHANNELS  = 4;                      // ADC lanes
    localparam int DATA_WIDTH    = 12;                     // Bits per sample
    localparam int FIFO_DEPTH    = 16;                     // Entries per channel FIFO
    localparam int FCO_HIGH_BITS = 6;                      // Leading bits with fco high
    localparam int CH_ADDR_W     = $clog2(NUM_CHANNELS);   // Read port channel select
    localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);     // FIFO pointer width
    localparam int DROP_CNT_W    = 16;                     // Dropped word counter

    // One converted sample
    typedef logic [DATA_WIDTH-1:0] sample_t;

    // All lanes side by side, index = channel
    typedef sample_t [NUM_CHANNELS-1:0] lane_words_t;

    // Framing result from the frame clock
    typedef struct packed {
        logic word_end;   // Last bit of a word in the shift registers
        logic locked;     // Two good frame edges in a row
    } frame_info_t;

    // Per FIFO flags
    typedef struct packed {
        logic not_empty;
        logic full;
    } fifo_status_t;

endpackage

`default_nettype wire

// File: compile.f
common/adc_pkg.sv
design/frame/frame_tracker.sv
design/lane/lane_deserializer.sv
design/sample_assembler.sv
design/sample_fifo.sv
design/channel_buffers.sv
design/ad9228_read.sv
tb/tb_ad9228_read.sv

// File: design/ad9228_read.sv
// Everything runs on dco; the ADC word is readable two edges after its last bit is sampled
`default_nettype none

module ad9228_read #(
    parameter logic DIN_INVERTED = 1'b0,   // Data pairs swapped on the board
    parameter logic FCO_INVERTED = 1'b0    // Frame pair swapped on the board
) (
    input  logic                             dco,
    input  logic                             fifo_rstn,
    input  logic                             read_en,
    input  logic [adc_pkg::NUM_CHANNELS-1:0] din,
    input  logic                             fco,
    input  logic [adc_pkg::CH_ADDR_W-1:0]    fifo_addr,
    input  logic [adc_pkg::NUM_CHANNELS-1:0] fifo_rd_en,
    output adc_pkg::sample_t                 fifo_dout,
    output logic                             fifo_not_empty,
    output logic                             fifo_full
);

    import adc_pkg::*;

    frame_info_t             frame;      // Framing from fco
    lane_words_t             words;      // Live shift register contents
    lane_words_t             wr_words;   // Captured words toward the FIFOs
    logic [NUM_CHANNELS-1:0] wr_en;
    logic [NUM_CHANNELS-1:0] full;       // Per channel, for drop decisions

    frame_tracker #(
        .FCO_INVERTED (FCO_INVERTED)
    ) u_frame_tracker (
        .dco       (dco),
        .fifo_rstn (fifo_rstn),
        .fco       (fco),
        .frame     (frame)
    );

    lane_deserializer #(
        .DIN_INVERTED (DIN_INVERTED)
    ) u_lane_deserializer (
        .dco       (dco),
        .fifo_rstn (fifo_rstn),
        .din       (din),
        .words     (words)
    );

    sample_assembler u_sample_assembler (
        .dco       (dco),
        .fifo_rstn (fifo_rstn),
        .read_en   (read_en),
        .frame     (frame),
        .words     (words),
        .full      (full),
        .wr_words  (wr_words),
        .wr_en     (wr_en)
    );

    channel_buffers u_channel_buffers (
        .dco            (dco),
        .fifo_rstn      (fifo_rstn),
        .wr_words       (wr_words),
        .wr_en          (wr_en),
        .fifo_rd_en     (fifo_rd_en),
        .fifo_addr      (fifo_addr),
        .full           (full),
        .fifo_dout      (fifo_dout),
        .fifo_not_empty (fifo_not_empty),
        .fifo_full      (fifo_full)
    );

endmodule

`default_nettype wire

// File: design/channel_buffers.sv
// Read side is combinational from fifo_addr; outputs read zero while fifo_rstn is low
`default_nettype none

module channel_buffers (
    input  logic                             dco,
    input  logic                             fifo_rstn,
    input  adc_pkg::lane_words_t             wr_words,
    input  logic [adc_pkg::NUM_CHANNELS-1:0] wr_en,
    input  logic [adc_pkg::NUM_CHANNELS-1:0] fifo_rd_en,
    input  logic [adc_pkg::CH_ADDR_W-1:0]    fifo_addr,
    output logic [adc_pkg::NUM_CHANNELS-1:0] full,
    output adc_pkg::sample_t                 fifo_dout,
    output logic                             fifo_not_empty,
    output logic                             fifo_full
);

    import adc_pkg::*;

    lane_words_t                        head;   // Head of each channel FIFO
    fifo_status_t [NUM_CHANNELS-1:0]    stat;   // Flags of each channel FIFO

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        sample_fifo u_fifo (
            .dco       (dco),
            .fifo_rstn (fifo_rstn),
            .wr_en     (wr_en[ch]),
            .wr_data   (wr_words[ch]),
            .rd_en     (fifo_rd_en[ch]),     // Each channel pops on its own
            .rd_data   (head[ch]),
            .status    (stat[ch])
        );

        assign full[ch] = stat[ch].full;    // Back to the assembler
    end

    // Addressed channel to the read port
    always_comb begin
        if (!fifo_rstn) begin
            fifo_dout      = '0;
            fifo_not_empty = 1'b0;
            fifo_full      = 1'b0;
        end else begin
            fifo_dout      = head[fifo_addr];
            fifo_not_empty = stat[fifo_addr].not_empty;
            fifo_full      = stat[fifo_addr].full;
        end
    end

endmodule

`default_nettype wire

// File: design/frame/frame_tracker.sv
// Frames are exactly DATA_WIDTH bits; the first two frames after reset or a bad edge are lost
`default_nettype none

module frame_tracker #(
    parameter logic FCO_INVERTED = 1'b0
) (
    input  logic                 dco,
    input  logic                 fifo_rstn,
    input  logic                 fco,
    output adc_pkg::frame_info_t frame
);

    import adc_pkg::*;

    // One value above DATA_WIDTH-1 so the counter can park when fco stops
    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    logic             fco_in;      // Pad value after polarity fix
    logic             fco_q;       // Input register, same stage as the lane shifters
    logic             fco_rise;    // Incoming bit starts a new word
    logic             at_last;     // Counter sits on the last bit
    logic             good_edge;
    logic [CNT_W-1:0] bit_cnt_q;   // Index of the bit held in fco_q
    logic             framed_q;    // Some edge seen since reset
    logic             good_q;      // One good edge already seen
    logic             locked_q;

    assign fco_in    = fco ^ FCO_INVERTED;
    assign fco_rise  = fco_in & ~fco_q;             // Low to high across the input register
    assign at_last   = (bit_cnt_q == CNT_W'(DATA_WIDTH - 1));
    assign good_edge = fco_rise & framed_q & at_last; // First edge after reset never counts

    always_ff @(posedge dco) begin
        if (!fifo_rstn) begin
            fco_q     <= 1'b0;
            bit_cnt_q <= '0;
            framed_q  <= 1'b0;
            good_q    <= 1'b0;
            locked_q  <= 1'b0;
        end else begin
            fco_q <= fco_in;
            if (fco_rise) begin
                bit_cnt_q <= '0;                    // Bit 0 of a new word
                framed_q  <= 1'b1;
                if (good_edge) begin
                    good_q   <= 1'b1;
                    locked_q <= locked_q | good_q;  // Second good edge in a row locks
                end else begin
                    good_q   <= 1'b0;               // Misplaced edge, start over
                    locked_q <= 1'b0;
                end
            end else if (bit_cnt_q != '1) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;      // Saturates at all ones
            end
        end
    end

    // Shift registers hold the full word while the counter reads DATA_WIDTH-1
    assign frame.word_end = at_last;
    assign frame.locked   = locked_q;

endmodule

`default_nettype wire

// File: design/lane/lane_deserializer.sv
// Single data rate only, one bit per lane per dco rising edge, MSB first
`default_nettype none

module lane_deserializer #(
    parameter logic DIN_INVERTED = 1'b0
) (
    input  logic                             dco,
    input  logic                             fifo_rstn,
    input  logic [adc_pkg::NUM_CHANNELS-1:0] din,
    output adc_pkg::lane_words_t             words
);

    import adc_pkg::*;

    logic [NUM_CHANNELS-1:0] din_in;    // Lane bits after polarity fix
    lane_words_t             shift_q;   // LSB is the input register of each lane

    // Swapped LVDS pairs on the board flip every lane
    assign din_in = din ^ {NUM_CHANNELS{DIN_INVERTED}};

    always_ff @(posedge dco) begin
        if (!fifo_rstn) begin
            shift_q <= '0;                  // Known contents before the first frame
        end else begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                // Older bits move up, so the first bit ends in the MSB
                shift_q[ch] <= {shift_q[ch][DATA_WIDTH-2:0], din_in[ch]};
            end
        end
    end

    // Complete word in every lane when word_end is high
    assign words = shift_q;

endmodule

`default_nettype wire

// File: design/sample_assembler.sv
// Writes all channels on the same word; a full channel loses that word, the others keep it
`default_nettype none

module sample_assembler (
    input  logic                             dco,
    input  logic                             fifo_rstn,
    input  logic                             read_en,
    input  adc_pkg::frame_info_t             frame,
    input  adc_pkg::lane_words_t             words,
    input  logic [adc_pkg::NUM_CHANNELS-1:0] full,
    output adc_pkg::lane_words_t             wr_words,
    output logic [adc_pkg::NUM_CHANNELS-1:0] wr_en
);

    import adc_pkg::*;

    logic                              accept;      // Locked word that software wants
    logic [$clog2(NUM_CHANNELS+1)-1:0] drop_now;    // Channels losing this word
    lane_words_t                       wr_words_q;
    logic [NUM_CHANNELS-1:0]           wr_en_q;
    logic [DROP_CNT_W-1:0]             drop_cnt_q;  // Total dropped words, wraps

    assign accept = frame.word_end & frame.locked & read_en;

    always_comb begin
        drop_now = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            drop_now = drop_now + (accept & full[ch]);
        end
    end

    // Payload only needs to be valid alongside wr_en
    always_ff @(posedge dco) begin
        if (accept) begin
            wr_words_q <= words;
        end
    end

    always_ff @(posedge dco) begin
        if (!fifo_rstn) begin
            wr_en_q    <= '0;
            drop_cnt_q <= '0;
        end else begin
            wr_en_q    <= accept ? ~full : '0;   // One cycle strobe per accepted word
            drop_cnt_q <= drop_cnt_q + DROP_CNT_W'(drop_now);
        end
    end

    assign wr_words = wr_words_q;
    assign wr_en    = wr_en_q;

endmodule

`default_nettype wire

// File: design/sample_fifo.sv
// Caller must never write while full; the head reads zero while the FIFO is empty
`default_nettype none

module sample_fifo (
    input  logic                  dco,
    input  logic                  fifo_rstn,
    input  logic                  wr_en,
    input  adc_pkg::sample_t      wr_data,
    input  logic                  rd_en,
    output adc_pkg::sample_t      rd_data,
    output adc_pkg::fifo_status_t status
);

    import adc_pkg::*;

    sample_t               mem [FIFO_DEPTH];   // Sample storage
    logic [FIFO_PTR_W-1:0] wr_ptr_q;           // Next free slot
    logic [FIFO_PTR_W-1:0] rd_ptr_q;           // Current head
    logic [FIFO_PTR_W:0]   count_q;            // Occupancy, 0 to FIFO_DEPTH
    logic                  empty;
    logic                  do_rd;              // Pop that really happens

    assign empty = (count_q == '0);
    assign do_rd = rd_en & ~empty;             // Pop on empty is ignored

    always_ff @(posedge dco) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= wr_data;
        end
    end

    always_ff @(posedge dco) begin
        if (!fifo_rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // Wraps at the power of two depth
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, do_rd})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;   // Both or neither
            endcase
        end
    end

    // First word falls through, the head is valid as soon as it is written
    assign rd_data = empty ? '0 : mem[rd_ptr_q];

    assign status.not_empty = ~empty;
    assign status.full      = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the readout testbench with Verilator
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ad9228_read \
    -f compile.f -o tb_ad9228_read
./obj_dir/tb_ad9228_read 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi

// File: tb/tb_ad9228_read.sv
// Default pin polarity only; one bit per lane per dco cycle, MSB first, fco high for six bits
`default_nettype none

module tb_ad9228_read;

    import adc_pkg::*;

    localparam int          HALF_PERIOD  = 50;
    localparam int          QUARTER      = 25;    // Sample point after each falling edge
    localparam int          RESET_CYCLES = 16;
    localparam int          WAIT_LIMIT   = 64;    // Cycles before a wait gives up
    localparam int          WORD_LATENCY = 3;     // Last bit sampled to fifo_dout
    localparam int          NUM_TESTS    = 5;
    localparam int          MAX_FRAMES   = FIFO_DEPTH + 5;
    localparam int          GLITCH_IDX   = 3;     // Frame sent with a late fco edge
    localparam int          GLITCH_SHIFT = 3;
    localparam logic [31:0] SEED         = 32'h4902f052;

    typedef struct packed {
        logic [7:0] n_frames;     // Frames sent, lock frames included
        logic       read_en;
        logic       glitch;       // Frame GLITCH_IDX is misplaced
        logic       addr_check;   // Per address head scan with a single pop
        logic [7:0] exp_count;    // Words stored per channel
    } test_row_t;

    logic                    dco = 1'b0;
    logic                    fifo_rstn;
    logic                    read_en;
    logic [NUM_CHANNELS-1:0] din;
    logic                    fco;
    logic [CH_ADDR_W-1:0]    fifo_addr;
    logic [NUM_CHANNELS-1:0] fifo_rd_en;
    sample_t                 fifo_dout;
    logic                    fifo_not_empty;
    logic                    fifo_full;

    test_row_t   rows [NUM_TESTS];
    string       names [NUM_TESTS];
    lane_words_t frames [NUM_TESTS][MAX_FRAMES];   // Lane data of every frame sent
    sample_t     exp_q [NUM_CHANNELS][$];          // Expected FIFO contents
    int          errors;
    int          test_errors;
    int          checks;
    int          failed_tests;

    ad9228_read DUT (
        .dco            (dco),
        .fifo_rstn      (fifo_rstn),
        .read_en        (read_en),
        .din            (din),
        .fco            (fco),
        .fifo_addr      (fifo_addr),
        .fifo_rd_en     (fifo_rd_en),
        .fifo_dout      (fifo_dout),
        .fifo_not_empty (fifo_not_empty),
        .fifo_full      (fifo_full)
    );

    always #HALF_PERIOD dco = ~dco;

    initial begin
        fifo_rstn = 1'b0;
        repeat (RESET_CYCLES) @(negedge dco);
        fifo_rstn = 1'b1;                          // Released on a falling edge
    end

    task automatic check_sample(input sample_t got, input sample_t exp, input int ch);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] t=%0t fifo_dout: got 0x%03h expected 0x%03h on channel %0d",
                     $time, got, exp, ch);
        end
    endtask

    task automatic check_status(input fifo_status_t got, input fifo_status_t exp, input int ch);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] t=%0t {fifo_not_empty,fifo_full}: got %b expected %b on channel %0d",
                     $time, got, exp, ch);
        end
    endtask

    function automatic fifo_status_t status_now();
        fifo_status_t s;
        s.not_empty = fifo_not_empty;
        s.full      = fifo_full;
        return s;
    endfunction

    // Flags a FIFO holding size words must show
    function automatic fifo_status_t status_for(input int size);
        fifo_status_t s;
        s.not_empty = (size > 0);
        s.full      = (size == FIFO_DEPTH);
        return s;
    endfunction

    task automatic send_frame(input lane_words_t w, input int shift);
        int pos;
        for (int b = 0; b < DATA_WIDTH; b++) begin
            @(negedge dco);
            pos = b - shift;
            fco = (pos >= 0) && (pos < FCO_HIGH_BITS);   // Shift moves the rising edge late
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                din[ch] = w[ch][DATA_WIDTH-1-b];         // MSB goes out first
            end
        end
    endtask

    // Back to back frames, reference queues filled as the frames go out
    task automatic send_burst(input int t);
        int   run;     // Clean frames in a row
        logic bad;
        run = 0;
        @(negedge dco);
        read_en = rows[t].read_en;
        for (int k = 0; k < int'(rows[t].n_frames); k++) begin
            bad = rows[t].glitch && (k == GLITCH_IDX);
            send_frame(frames[t][k], bad ? GLITCH_SHIFT : 0);
            // Lock needs good edges at the start of this frame and the one before
            run = bad ? 0 : run + 1;
            if (!bad && run >= 3 && rows[t].read_en) begin
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    if (exp_q[ch].size() < FIFO_DEPTH) begin
                        exp_q[ch].push_back(frames[t][k][ch]);   // Full FIFO drops it
                    end
                end
            end
        end
        @(negedge dco);
        fco = 1'b0;
        din = '0;
        repeat (WORD_LATENCY) @(negedge dco);     // Fixed path to the read port
    endtask

    task automatic read_back(input int ch);
        int cycles;
        @(negedge dco);
        fifo_addr = CH_ADDR_W'(ch);
        #QUARTER;
        cycles = 0;
        while (exp_q[ch].size() > 0 && !fifo_not_empty && cycles < WAIT_LIMIT) begin
            @(negedge dco);
            #QUARTER;
            cycles++;
        end
        if (exp_q[ch].size() > 0 && !fifo_not_empty) begin
            $display("Timeout: channel %0d never raised fifo_not_empty", ch);
            $display("Regression failed");
            $finish;
        end
        // Pop every cycle, head checked before the rising edge takes it
        while (exp_q[ch].size() > 0) begin
            @(negedge dco);
            fifo_rd_en = NUM_CHANNELS'(1) << ch;
            #QUARTER;
            check_status(status_now(), status_for(exp_q[ch].size()), ch);
            check_sample(fifo_dout, exp_q[ch].pop_front(), ch);
        end
        @(negedge dco);
        fifo_rd_en = '0;
        #QUARTER;
        check_status(status_now(), status_for(0), ch);   // Drained
    endtask

    // Each address checked before the next rising edge
    task automatic scan_heads();
        for (int a = 0; a < NUM_CHANNELS; a++) begin
            @(negedge dco);
            fifo_addr = CH_ADDR_W'(a);
            #QUARTER;
            if (exp_q[a].size() > 0) begin
                check_sample(fifo_dout, exp_q[a][0], a);
            end
            check_status(status_now(), status_for(exp_q[a].size()), a);
        end
    endtask

    task automatic reset_outputs_zero();
        for (int a = 0; a < NUM_CHANNELS; a++) begin
            @(negedge dco);
            fifo_addr = CH_ADDR_W'(a);
            #QUARTER;
            check_sample(fifo_dout, '0, a);
            check_status(status_now(), status_for(0), a);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!fifo_rstn && cycles < WAIT_LIMIT) begin
            @(negedge dco);
            #QUARTER;
            cycles++;
        end
        if (!fifo_rstn) begin
            $display("Timeout: fifo_rstn was never released");
            $display("Regression failed");
            $finish;
        end
    endtask

    task automatic build_table();
        rows[0]  = '{n_frames: 8'd6, read_en: 1'b1, glitch: 1'b0, addr_check: 1'b0,
                     exp_count: 8'd4};
        names[0] = "lock and capture";
        rows[1]  = '{n_frames: 8'd5, read_en: 1'b0, glitch: 1'b0, addr_check: 1'b0,
                     exp_count: 8'd0};
        names[1] = "read_en gating";
        rows[2]  = '{n_frames: 8'd9, read_en: 1'b1, glitch: 1'b1, addr_check: 1'b0,
                     exp_count: 8'd4};
        names[2] = "misplaced frame edge";
        rows[3]  = '{n_frames: 8'(FIFO_DEPTH + 5), read_en: 1'b1, glitch: 1'b0,
                     addr_check: 1'b0, exp_count: 8'(FIFO_DEPTH)};
        names[3] = "overflow";
        rows[4]  = '{n_frames: 8'd5, read_en: 1'b1, glitch: 1'b0, addr_check: 1'b1,
                     exp_count: 8'd3};
        names[4] = "addressing";
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int k = 0; k < MAX_FRAMES; k++) begin
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    frames[t][k][ch] = sample_t'($urandom);
                end
            end
        end
        // Extreme codes and alternating bits on the first stored frames
        frames[0][2] = {12'h5A5, 12'hA5A, 12'h000, 12'hFFF};
        frames[0][3] = {12'h001, 12'h800, 12'h7FF, 12'hFFE};
    endtask

    task automatic run_row(input int t);
        send_burst(t);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (exp_q[ch].size() != int'(rows[t].exp_count)) begin
                errors++;
                test_errors++;
                $display("Reference holds %0d words on channel %0d but the table expects %0d",
                         exp_q[ch].size(), ch, rows[t].exp_count);
            end
        end
        if (rows[t].addr_check) begin
            scan_heads();
            @(negedge dco);
            fifo_addr  = CH_ADDR_W'(1);
            fifo_rd_en = NUM_CHANNELS'(2);         // Pop channel 1 only
            @(negedge dco);
            fifo_rd_en = '0;
            void'(exp_q[1].pop_front());
            scan_heads();                          // Other heads untouched
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            read_back(ch);
        end
    endtask

    task automatic report_test(input int n, input string name);
        if (test_errors == 0) begin
            $display("Test %0d %s: ok", n, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", n, name, test_errors);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        read_en      = 1'b0;
        din          = '0;
        fco          = 1'b0;
        fifo_addr    = '0;
        fifo_rd_en   = '0;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        build_table();

        test_errors = 0;
        reset_outputs_zero();                      // While fifo_rstn is low
        wait_reset_release();
        reset_outputs_zero();                      // Just after release
        report_test(0, "reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            run_row(t);
            report_test(t + 1, names[t]);
        end

        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 NUM_TESTS + 1, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
